/* hw/csi2_rx_pkg.sv */
package csi2_rx_pkg;

  localparam int PX_W   = 16;
  localparam int WORD_W = 32;

  // Entry layout {eol, sof, pix_hi, pix_lo}
  localparam int FIFO_W = WORD_W + 2;

  localparam int CNT_W  = 32;

  // Data type codes
  localparam logic [5:0] DT_FS       = 6'h00;
  localparam logic [5:0] DT_FE       = 6'h01;
  localparam logic [5:0] DT_LONG_MIN = 6'h10;
  localparam logic [5:0] DT_YUV422_8 = 6'h1e;

  // Short packet view, frame start or frame end
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] frame_num;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } csi2_short_hdr_t;

  // Long packet view, word count in bytes
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_cnt;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } csi2_long_hdr_t;

  // One header word, two decodings
  typedef union packed {
    csi2_short_hdr_t sp;
    csi2_long_hdr_t  lp;
  } csi2_hdr_u;

endpackage

/* hw/csi2_pkt_parser.sv */
`timescale 1ns/1ps

module csi2_pkt_parser (
  input                                    px_clk_i,
  input                                    rst_n_i,

  // Merged lane words
  input        [csi2_rx_pkg::WORD_W-1 : 0] word_i,
  input                                    word_valid_i,
  input                                    sot_i,

  input                                    clear_stat_i,

  // Pixel-pair FIFO write side
  input                                    fifo_full_i,
  output logic                             fifo_wr_en_o,
  output logic [csi2_rx_pkg::FIFO_W-1 : 0] fifo_wr_data_o,

  // Statistics
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  hdr_err_cnt_o,
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  trunc_err_cnt_o,
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  overflow_cnt_o,
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  lines_per_frame_o
);

  import csi2_rx_pkg::*;

  csi2_hdr_u           hdr;
  logic                hdr_stb;
  logic                is_long;
  logic                long_ok;

  // Words still owed by the current long packet
  logic [13 : 0]       pay_cnt;
  logic                pay_keep;
  logic                pay_word;
  logic                last_word;

  logic                sof_pend;
  logic [CNT_W-1 : 0]  line_cnt;

  // One-cycle write stage
  logic                st_valid;
  logic [FIFO_W-1 : 0] st_data;

  assign hdr       = word_i;
  assign hdr_stb   = word_valid_i && sot_i;
  assign is_long   = hdr.lp.dt >= DT_LONG_MIN;
  assign long_ok   = (hdr.lp.dt == DT_YUV422_8) &&
                     (hdr.lp.word_cnt != '0) &&
                     (hdr.lp.word_cnt[1 : 0] == 2'b00);
  assign pay_word  = word_valid_i && !sot_i && (pay_cnt != '0);
  assign last_word = pay_cnt == 14'd1;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pay_cnt  <= '0;
      pay_keep <= 1'b0;
      sof_pend <= 1'b0;
      line_cnt <= '0;
    end else if (hdr_stb) begin
      if (is_long) begin
        // Rejected packets are skipped by whole words
        pay_cnt  <= hdr.lp.word_cnt[15 : 2];
        pay_keep <= long_ok;
      end else begin
        pay_cnt  <= '0;
        pay_keep <= 1'b0;
        if (hdr.sp.dt == DT_FS) begin
          sof_pend <= 1'b1;
          line_cnt <= '0;
        end
      end
    end else if (pay_word) begin
      pay_cnt <= pay_cnt - 1'b1;
      if (pay_keep) begin
        sof_pend <= 1'b0;
        if (last_word)
          line_cnt <= line_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      st_valid <= 1'b0;
    else
      st_valid <= pay_word && pay_keep;
  end

  always_ff @(posedge px_clk_i) begin
    if (pay_word)
      st_data <= {last_word, sof_pend, word_i};
  end

  // The PHY has no back-pressure so a full FIFO drops the word
  assign fifo_wr_en_o   = st_valid && !fifo_full_i;
  assign fifo_wr_data_o = st_data;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hdr_err_cnt_o     <= '0;
      trunc_err_cnt_o   <= '0;
      overflow_cnt_o    <= '0;
      lines_per_frame_o <= '0;
    end else if (clear_stat_i) begin
      hdr_err_cnt_o     <= '0;
      trunc_err_cnt_o   <= '0;
      overflow_cnt_o    <= '0;
      lines_per_frame_o <= '0;
    end else begin
      if (hdr_stb) begin
        if (pay_keep && (pay_cnt != '0))
          trunc_err_cnt_o <= trunc_err_cnt_o + 1'b1;
        if (is_long && !long_ok)
          hdr_err_cnt_o <= hdr_err_cnt_o + 1'b1;
        if (!is_long && (hdr.sp.dt == DT_FE))
          lines_per_frame_o <= line_cnt;
      end
      if (st_valid && fifo_full_i)
        overflow_cnt_o <= overflow_cnt_o + 1'b1;
    end
  end

  // Full can only rise right after a write
  a_full_after_write : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i)
      $rose(fifo_full_i) |-> $past(fifo_wr_en_o)
  );

endmodule

/* hw/csi2_px_fifo.sv */
`timescale 1ns/1ps

module csi2_px_fifo #(
  parameter int DEPTH = 16
)(
  input                                    px_clk_i,
  input                                    rst_n_i,

  input                                    wr_en_i,
  input        [csi2_rx_pkg::FIFO_W-1 : 0] wr_data_i,

  input                                    rd_en_i,
  output logic [csi2_rx_pkg::FIFO_W-1 : 0] rd_data_o,

  output logic                             full_o,
  output logic                             empty_o
);

  import csi2_rx_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [FIFO_W-1 : 0] mem [DEPTH];

  // Extra MSB tells full from empty
  logic [AW : 0]       wr_ptr;
  logic [AW : 0]       rd_ptr;
  logic [AW : 0]       wr_ptr_d;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      wr_ptr_d <= '0;
    end else begin
      if (wr_en_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en_i)
        rd_ptr <= rd_ptr + 1'b1;
      wr_ptr_d <= wr_ptr;
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (wr_en_i)
      mem[wr_ptr[AW-1 : 0]] <= wr_data_i;
  end

  always_ff @(posedge px_clk_i) begin
    if (rd_en_i)
      rd_data_o <= mem[rd_ptr[AW-1 : 0]];
  end

  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1 : 0] == rd_ptr[AW-1 : 0]);

  // New entries show up one cycle after the write
  assign empty_o = rd_ptr == wr_ptr_d;

  a_no_overflow : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i)
      wr_en_i |-> !full_o
  );

  a_no_underflow : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i)
      rd_en_i |-> !empty_o
  );

endmodule

/* hw/csi2_video_out.sv */
`timescale 1ns/1ps

module csi2_video_out (
  input                                    px_clk_i,
  input                                    rst_n_i,

  input                                    clear_stat_i,

  // FIFO read side
  input        [csi2_rx_pkg::FIFO_W-1 : 0] rd_data_i,
  input                                    empty_i,
  output logic                             rd_en_o,

  // AXI4-Stream video
  input                                    video_tready_i,
  output logic [csi2_rx_pkg::PX_W-1 : 0]   video_tdata_o,
  output logic                             video_tvalid_o,
  output logic                             video_tuser_o,
  output logic                             video_tlast_o,

  // Line length statistics
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  max_px_per_ln_o,
  output logic [csi2_rx_pkg::CNT_W-1 : 0]  min_px_per_ln_o
);

  import csi2_rx_pkg::*;

  logic                fire;
  logic                load;

  // Entry read from the FIFO, not yet in the holding register
  logic                pend;

  logic                hold_valid;
  logic                beat_sel;
  logic [WORD_W-1 : 0] hold_pair;
  logic                hold_sof;
  logic                hold_eol;

  logic [CNT_W-1 : 0]  px_cnt;
  logic [CNT_W-1 : 0]  line_len;

  assign fire = hold_valid && video_tready_i;
  assign load = pend && (!hold_valid || (beat_sel && video_tready_i));

  // Prefetch on the first beat keeps entries back to back
  assign rd_en_o = !empty_i && !pend && (!hold_valid || fire);

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend       <= 1'b0;
      hold_valid <= 1'b0;
      beat_sel   <= 1'b0;
    end else begin
      if (rd_en_o)
        pend <= 1'b1;
      else if (load)
        pend <= 1'b0;

      if (load) begin
        hold_valid <= 1'b1;
        beat_sel   <= 1'b0;
      end else if (fire) begin
        if (beat_sel)
          hold_valid <= 1'b0;
        beat_sel <= !beat_sel;
      end
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (load)
      {hold_eol, hold_sof, hold_pair} <= rd_data_i;
  end

  // Low pixel goes out first
  assign video_tdata_o  = beat_sel ? hold_pair[WORD_W-1 : PX_W] : hold_pair[PX_W-1 : 0];
  assign video_tvalid_o = hold_valid;
  assign video_tuser_o  = hold_valid && hold_sof && !beat_sel;
  assign video_tlast_o  = hold_valid && hold_eol && beat_sel;

  assign line_len = px_cnt + 1'b1;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      px_cnt          <= '0;
      max_px_per_ln_o <= '0;
      min_px_per_ln_o <= '1;
    end else begin
      if (fire) begin
        if (video_tlast_o)
          px_cnt <= '0;
        else if (video_tuser_o)
          px_cnt <= CNT_W'(1);
        else
          px_cnt <= line_len;
      end

      if (clear_stat_i) begin
        max_px_per_ln_o <= '0;
        min_px_per_ln_o <= '1;
      end else if (fire && video_tlast_o) begin
        if (line_len > max_px_per_ln_o)
          max_px_per_ln_o <= line_len;
        if (line_len < min_px_per_ln_o)
          min_px_per_ln_o <= line_len;
      end
    end
  end

  // Stalled beat must not change under the sink
  a_hold_on_stall : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i)
      (video_tvalid_o && !video_tready_i) |=>
        (video_tvalid_o && $stable(video_tdata_o) &&
         $stable(video_tuser_o) && $stable(video_tlast_o))
  );

endmodule

/* hw/csi2_video_rx_top.sv */
`timescale 1ns/1ps

module csi2_video_rx_top #(
  parameter int FIFO_DEPTH = 16
)(
  // Pixel clock domain
  input                                    px_clk_i,
  input                                    rst_n_i,

  // Merged two-lane words
  input        [csi2_rx_pkg::WORD_W-1 : 0] word_i,
  input                                    word_valid_i,
  input                                    sot_i,

  input                                    clear_stat_i,

  // Output AXI4-Stream video
  input                                    video_tready_i,
  output       [csi2_rx_pkg::PX_W-1 : 0]   video_tdata_o,
  output                                   video_tvalid_o,
  output                                   video_tuser_o,
  output                                   video_tlast_o,

  // Statistics
  output       [csi2_rx_pkg::CNT_W-1 : 0]  hdr_err_cnt_o,
  output       [csi2_rx_pkg::CNT_W-1 : 0]  trunc_err_cnt_o,
  output       [csi2_rx_pkg::CNT_W-1 : 0]  overflow_cnt_o,
  output       [csi2_rx_pkg::CNT_W-1 : 0]  lines_per_frame_o,
  output       [csi2_rx_pkg::CNT_W-1 : 0]  max_px_per_ln_o,
  output       [csi2_rx_pkg::CNT_W-1 : 0]  min_px_per_ln_o
);

  import csi2_rx_pkg::*;

  logic                fifo_wr_en;
  logic [FIFO_W-1 : 0] fifo_wr_data;
  logic                fifo_full;
  logic                fifo_rd_en;
  logic [FIFO_W-1 : 0] fifo_rd_data;
  logic                fifo_empty;

  csi2_pkt_parser csi2_pkt_parser (
    .px_clk_i          ( px_clk_i          ),
    .rst_n_i           ( rst_n_i           ),
    .word_i            ( word_i            ),
    .word_valid_i      ( word_valid_i      ),
    .sot_i             ( sot_i             ),
    .clear_stat_i      ( clear_stat_i      ),
    .fifo_full_i       ( fifo_full         ),
    .fifo_wr_en_o      ( fifo_wr_en        ),
    .fifo_wr_data_o    ( fifo_wr_data      ),
    .hdr_err_cnt_o     ( hdr_err_cnt_o     ),
    .trunc_err_cnt_o   ( trunc_err_cnt_o   ),
    .overflow_cnt_o    ( overflow_cnt_o    ),
    .lines_per_frame_o ( lines_per_frame_o )
  );

  csi2_px_fifo #(
    .DEPTH     ( FIFO_DEPTH   )
  ) csi2_px_fifo (
    .px_clk_i  ( px_clk_i     ),
    .rst_n_i   ( rst_n_i      ),
    .wr_en_i   ( fifo_wr_en   ),
    .wr_data_i ( fifo_wr_data ),
    .rd_en_i   ( fifo_rd_en   ),
    .rd_data_o ( fifo_rd_data ),
    .full_o    ( fifo_full    ),
    .empty_o   ( fifo_empty   )
  );

  csi2_video_out csi2_video_out (
    .px_clk_i        ( px_clk_i        ),
    .rst_n_i         ( rst_n_i         ),
    .clear_stat_i    ( clear_stat_i    ),
    .rd_data_i       ( fifo_rd_data    ),
    .empty_i         ( fifo_empty      ),
    .rd_en_o         ( fifo_rd_en      ),
    .video_tready_i  ( video_tready_i  ),
    .video_tdata_o   ( video_tdata_o   ),
    .video_tvalid_o  ( video_tvalid_o  ),
    .video_tuser_o   ( video_tuser_o   ),
    .video_tlast_o   ( video_tlast_o   ),
    .max_px_per_ln_o ( max_px_per_ln_o ),
    .min_px_per_ln_o ( min_px_per_ln_o )
  );

endmodule

/* tests/tb_csi2_video_rx.sv */
`timescale 1ns/1ps

module tb_csi2_video_rx;

  localparam int DEPTH = 16;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] word;
  logic        word_valid;
  logic        sot;
  logic        clear;
  logic        tready;
  logic [15:0] tdata;
  logic        tvalid;
  logic        tuser;
  logic        tlast;
  logic [31:0] hdr_err;
  logic [31:0] trunc_err;
  logic [31:0] ovf;
  logic [31:0] lines;
  logic [31:0] max_px;
  logic [31:0] min_px;

  // Expected beats {tuser, tlast, tdata}
  logic [17:0] exp_q[$];
  int          errors = 0;
  int          seed = 32'h4b3e_11f7;
  int          mode = 0;
  int          low_cnt = 0;

  // Reference model of the accepted-packet rule
  int          pay = 0;
  logic        keep = 1'b0;
  logic        sof_pend = 1'b0;
  logic        stall = 1'b0;
  int          held = 0;

  csi2_video_rx_top #(.FIFO_DEPTH(DEPTH)) uut (
    .px_clk_i(clk), .rst_n_i(rst_n), .word_i(word), .word_valid_i(word_valid),
    .sot_i(sot), .clear_stat_i(clear), .video_tready_i(tready),
    .video_tdata_o(tdata), .video_tvalid_o(tvalid), .video_tuser_o(tuser),
    .video_tlast_o(tlast), .hdr_err_cnt_o(hdr_err), .trunc_err_cnt_o(trunc_err),
    .overflow_cnt_o(ovf), .lines_per_frame_o(lines), .max_px_per_ln_o(max_px),
    .min_px_per_ln_o(min_px)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n && tvalid && tready) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Unexpected beat on the video stream at %0t", $time);
      end
      if (exp_q.size() > 0) begin
        assert ({tuser, tlast, tdata} == exp_q[0]) else begin
          errors++;
          $display("Fail {video_tuser_o,video_tlast_o,video_tdata_o}: got %h expected %h",
                   {tuser, tlast, tdata}, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    word_valid = 1'b0;
    sot = 1'b0;
    clear = 1'b0;
    if (mode == 0) begin
      tready = 1'b1;
    end else if (mode == 1) begin
      tready = 1'($random(seed));
    end else if (low_cnt > 0) begin
      tready = 1'b0;
      low_cnt--;
    end else begin
      tready = 1'b1;
    end
  endtask

  task automatic model_word(input logic s, input logic [31:0] w);
    if (s) begin
      if (w[5:0] >= 6'h10) begin
        pay = int'(w[23:10]);
        keep = (w[5:0] == 6'h1e) && (w[23:8] != 16'h0) && (w[9:8] == 2'b00);
      end else begin
        pay = 0;
        keep = 1'b0;
        if (w[5:0] == 6'h00)
          sof_pend = 1'b1;
      end
    end else if (pay > 0) begin
      pay--;
      if (keep) begin
        // Under stall only FIFO plus holding register fit
        if (!stall || held < DEPTH + 1) begin
          exp_q.push_back({sof_pend, 1'b0, w[15:0]});
          exp_q.push_back({1'b0, pay == 0, w[31:16]});
          if (stall)
            held++;
        end
        sof_pend = 1'b0;
      end
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() > 0 || tvalid) && n < 3000) begin
      next_cycle();
      n++;
    end
    if (n >= 3000) begin
      errors++;
      $display("Timeout waiting for the video stream to drain");
    end
    stall = 1'b0;
  endtask

  function automatic string stat_port(input string name);
    case (name)
      "hdr":   return "hdr_err_cnt_o";
      "trunc": return "trunc_err_cnt_o";
      "ovf":   return "overflow_cnt_o";
      "lines": return "lines_per_frame_o";
      "max":   return "max_px_per_ln_o";
      default: return "min_px_per_ln_o";
    endcase
  endfunction

  task automatic check_stat(input string name, input logic [31:0] exp);
    logic [31:0] got;
    next_cycle();
    next_cycle();
    case (name)
      "hdr":   got = hdr_err;
      "trunc": got = trunc_err;
      "ovf":   got = ovf;
      "lines": got = lines;
      "max":   got = max_px;
      default: got = min_px;
    endcase
    assert (got == exp) else begin
      errors++;
      $display("Fail %s: got %h expected %h", stat_port(name), got, exp);
    end
  endtask

  initial begin
    int          fd;
    int          r;
    string       op;
    string       name;
    string       rest;
    logic        s;
    logic [31:0] w;
    logic [31:0] n;
    word = '0;
    word_valid = 1'b0;
    sot = 1'b0;
    clear = 1'b0;
    tready = 1'b1;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("tests/csi2_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      $display("*** FAILED ***");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.getc(0) == "#") begin
          r = $fgets(rest, fd);
        end else if (op == "W") begin
          r = $fscanf(fd, "%h %h %h", s, w, n);
          repeat (n) begin
            next_cycle();
            word = w;
            sot = s;
            word_valid = 1'b1;
            model_word(s, w);
            w++;
          end
        end else if (op == "T") begin
          r = $fscanf(fd, "%h %h", mode, low_cnt);
          if (mode == 2) begin
            stall = 1'b1;
            held = 0;
          end
        end else if (op == "C") begin
          next_cycle();
          clear = 1'b1;
        end else if (op == "P") begin
          drain();
        end else if (op == "X") begin
          r = $fscanf(fd, "%s %h", name, w);
          check_stat(name, w);
        end else begin
          errors++;
          $display("Unknown operation %s in the stimulus file", op);
        end
      end
      $fclose(fd);
      drain();
      $display("Run complete, errors: %0d", errors);
      if (errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

/* csi2_video_rx_top.f */
hw/csi2_rx_pkg.sv
hw/csi2_pkt_parser.sv
hw/csi2_px_fifo.sv
hw/csi2_video_out.sv
hw/csi2_video_rx_top.sv
tests/tb_csi2_video_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSI-2 video receiver testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f csi2_video_rx_top.f \
  --top-module tb_csi2_video_rx -o sim_csi2 &&
./obj_dir/sim_csi2 | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tests/csi2_stimulus.txt */
# W sot word count : count words from word, incrementing | T mode cycles : 0 high 1 random 2 low
# C clear | P drain | X name value : hdr trunc ovf lines max min, all fields hex
X min ffffffff
T 1 0
W 1 00000100 1
W 1 0000101e 1
W 0 11110000 4
W 1 0000081e 1
W 0 22220000 2
W 1 0000101e 1
W 0 33330000 4
W 1 00000101 1
X lines 3
W 1 00000200 1
W 1 0000101e 1
W 0 44440000 4
W 1 0000081e 1
W 0 55550000 2
W 1 0000101e 1
W 0 66660000 4
W 1 00000201 1
P
X lines 3
X max 8
X min 4
W 1 0000082a 1
W 0 77770000 2
W 1 0000061e 1
W 0 88880000 1
P
X hdr 2
W 1 0000101e 1
W 0 99990000 2
W 1 0000081e 1
W 0 aaaa0000 2
P
X trunc 1
T 2 80
W 1 0000a01e 1
W 0 bbbb0000 28
P
X ovf 17
C
X hdr 0
X trunc 0
X ovf 0
X lines 0
X max 0
X min ffffffff
